/* Makefile */
SIM      ?= verilator
TOP      ?= tb_vec_addsub_unit
FILELIST ?= sim.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINT     ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Something failed" $(LOG) || ! grep -q "Everything OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim.f */
source/vec_types_pkg.sv
source/vec_op_pkg.sv
source/vaddsub.sv
source/elem_counter.sv
source/addsub_ctrl.sv
source/operand_bank.sv
source/result_bank.sv
source/vec_addsub_unit.sv
tb/tb_vec_addsub_unit.sv

/* source/addsub_ctrl.sv */
// group sequencing FSM with the four-phase req/ack handshake
`timescale 1ns/1ps
`default_nettype none

module addsub_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    req_i,
    input  logic                    last_i,      // counter sits on the last word
    input  vec_op_pkg::instr_type_t op_i,
    input  vec_op_pkg::sew_t        sew_i,
    input  logic                    use_mask_i,
    output logic                    ack_o,
    output logic                    cnt_clear_o,
    output logic                    cnt_step_o,
    output logic                    res_we_o     // store the datapath result
);
    import vec_types_pkg::*;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } state_t;

    state_t state_q;
    state_t state_d;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (req_i) state_d = RUN;
            RUN:     if (last_i) state_d = DONE;   // last word written on this edge
            DONE:    if (!req_i) state_d = IDLE;   // host closed the handshake
            default: state_d = IDLE;
        endcase
    end

    assign cnt_clear_o = (state_q == IDLE) && req_i;
    assign cnt_step_o  = (state_q == RUN) && !last_i;
    assign res_we_o    = (state_q == RUN);
    assign ack_o       = (state_q == DONE);

    // operation fields stay put until req drops
    a_op_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i |=> (!req_i || $stable({op_i, sew_i, use_mask_i})));

    // one cycle per word between the accepting edge and ack
    a_ack_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == IDLE && req_i) |=> !ack_o [*NUM_WORDS] ##1 ack_o);

endmodule

`default_nettype wire

/* source/elem_counter.sv */
// word index counter with clear, step and last-word flag
`timescale 1ns/1ps
`default_nettype none

module elem_counter (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     clear_i,  // back to word 0
    input  logic                     step_i,   // next word
    output vec_types_pkg::word_idx_t idx_o,
    output logic                     last_o
);
    import vec_types_pkg::*;

    word_idx_t idx_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            idx_q <= '0;
        end else if (clear_i) begin
            idx_q <= '0;
        end else if (step_i) begin
            idx_q <= idx_q + word_idx_t'(1);
        end
    end

    assign idx_o  = idx_q;
    assign last_o = (idx_q == word_idx_t'(NUM_WORDS - 1));

    // the group ends at the last word, the index must not wrap
    a_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (step_i && !clear_i) |-> !last_o);

endmodule

`default_nettype wire

/* source/operand_bank.sv */
// vs2/vs1/mask operand storage with host write port and sequencer read port
`timescale 1ns/1ps
`default_nettype none

module operand_bank (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     wr_en_i,
    input  vec_types_pkg::word_idx_t wr_addr_i,
    input  vec_types_pkg::bus64_t    wr_vs2_i,
    input  vec_types_pkg::bus64_t    wr_vs1_i,
    input  vec_types_pkg::vmask_t    wr_mask_i,
    input  logic                     busy_i,     // group in flight
    input  vec_types_pkg::word_idx_t rd_addr_i,
    output vec_types_pkg::bus64_t    vs2_o,
    output vec_types_pkg::bus64_t    vs1_o,
    output vec_types_pkg::vmask_t    mask_o
);

    vec_types_pkg::bus64_t vs2_q  [vec_types_pkg::NUM_WORDS];
    vec_types_pkg::bus64_t vs1_q  [vec_types_pkg::NUM_WORDS];
    vec_types_pkg::vmask_t mask_q [vec_types_pkg::NUM_WORDS];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < vec_types_pkg::NUM_WORDS; i++) begin
                vs2_q[i]  <= '0;
                vs1_q[i]  <= '0;
                mask_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            vs2_q[wr_addr_i]  <= wr_vs2_i;
            vs1_q[wr_addr_i]  <= wr_vs1_i;
            mask_q[wr_addr_i] <= wr_mask_i;
        end
    end

    assign vs2_o  = vs2_q[rd_addr_i];   // combinational read
    assign vs1_o  = vs1_q[rd_addr_i];
    assign mask_o = mask_q[rd_addr_i];

    // operands must not change under a running group
    a_no_write_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_en_i |-> !busy_i);

endmodule

`default_nettype wire

/* source/result_bank.sv */
// result word storage, sequencer write and host read
`timescale 1ns/1ps
`default_nettype none

module result_bank (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     we_i,
    input  vec_types_pkg::word_idx_t wr_addr_i,  // from the word counter
    input  vec_types_pkg::bus64_t    wr_data_i,
    input  vec_types_pkg::word_idx_t rd_addr_i,  // from the host
    output vec_types_pkg::bus64_t    rd_data_o
);

    vec_types_pkg::bus64_t res_q [vec_types_pkg::NUM_WORDS];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < vec_types_pkg::NUM_WORDS; i++) begin
                res_q[i] <= '0;
            end
        end else if (we_i) begin
            res_q[wr_addr_i] <= wr_data_i;
        end
    end

    // host sees the stored word in the same cycle
    assign rd_data_o = res_q[rd_addr_i];

endmodule

`default_nettype wire

/* source/vaddsub.sv */
// packed-SIMD add/subtract datapath built from chained byte adders
`timescale 1ns/1ps
`default_nettype none

module vaddsub (
    input  vec_op_pkg::instr_type_t instr_type_i,  // operation
    input  vec_op_pkg::sew_t        sew_i,         // element width
    input  logic                    use_mask_i,    // masked form of VMADC/VMSBC
    input  vec_types_pkg::bus64_t   data_vs1_i,
    input  vec_types_pkg::bus64_t   data_vs2_i,
    input  vec_types_pkg::vmask_t   data_vm_i,     // carry/borrow per element
    output vec_types_pkg::bus64_t   data_vd_o
);
    import vec_types_pkg::*;
    import vec_op_pkg::*;

    logic                      is_sub;      // carry-in of 1 at each element
    logic                      is_borrow;   // borrow taken from the mask
    logic                      is_carry;    // carry taken from the mask
    logic                      is_mask_op;  // result is a mask byte
    bus64_t                    opa;         // vs2 side
    bus64_t                    opb;         // vs1 side
    vmask_t                    chain;       // byte continues the element below it
    logic [NUM_BYTES-1:0][8:0] sum;         // byte sums with carry out
    bus64_t                    sum_bytes;
    vmask_t                    flags;       // per-element carry or borrow
    logic                      cin;
    logic                      carry;
    int                        elem;
    int                        last;

    assign is_sub     = (instr_type_i == VSUB) || (instr_type_i == VRSUB) ||
                        (instr_type_i == VMSBC && !use_mask_i);
    assign is_borrow  = (instr_type_i == VSBC) || (instr_type_i == VMSBC && use_mask_i);
    assign is_carry   = (instr_type_i == VADC) || (instr_type_i == VMADC && use_mask_i);
    assign is_mask_op = (instr_type_i == VMADC) || (instr_type_i == VMSBC);

    // subtraction goes through the adder as a + ~b + 1
    always_comb begin
        opa = data_vs2_i;
        opb = data_vs1_i;
        case (instr_type_i)
            VRSUB:             opa = ~data_vs2_i;
            VSUB, VSBC, VMSBC: opb = ~data_vs1_i;
            default:           ;
        endcase
    end

    // which byte adders hand their carry to the next one
    always_comb begin
        case (sew_i)
            SEW_16:  chain = 8'b1010_1010;
            SEW_32:  chain = 8'b1110_1110;
            SEW_64:  chain = 8'b1111_1110;
            default: chain = 8'b0000_0000;
        endcase
    end

    always_comb begin
        cin   = 1'b0;
        carry = 1'b0;
        elem  = 0;
        for (int b = 0; b < NUM_BYTES; b++) begin
            elem = b >> sew_i;  // element that owns this byte
            if (chain[b]) begin
                cin = carry;
            end else if (is_sub) begin
                cin = 1'b1;
            end else if (is_borrow) begin
                cin = ~data_vm_i[elem];  // the +1 of the negation, minus the borrow
            end else if (is_carry) begin
                cin = data_vm_i[elem];
            end else begin
                cin = 1'b0;
            end
            sum[b] = {1'b0, opa[8*b +: 8]} + {1'b0, opb[8*b +: 8]} + {8'b0, cin};
            sum_bytes[8*b +: 8] = sum[b][7:0];
            carry = sum[b][8];
        end
    end

    // carry out of each element's top byte, borrow is its complement
    always_comb begin
        flags = '1;  // ones above the last element
        last  = 0;
        for (int k = 0; k < NUM_BYTES; k++) begin
            last = ((k + 1) << sew_i) - 1;
            if (last < NUM_BYTES) begin
                flags[k] = (instr_type_i == VMSBC) ? ~sum[last][8] : sum[last][8];
            end
        end
    end

    assign data_vd_o = is_mask_op ? {{(WORD_W - NUM_BYTES){1'b1}}, flags} : sum_bytes;

endmodule

`default_nettype wire

/* source/vec_addsub_unit.sv */
// top level of the vector add/subtract unit
`timescale 1ns/1ps
`default_nettype none

module vec_addsub_unit (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     wr_en_i,
    input  vec_types_pkg::word_idx_t wr_addr_i,
    input  vec_types_pkg::bus64_t    wr_vs2_i,
    input  vec_types_pkg::bus64_t    wr_vs1_i,
    input  vec_types_pkg::vmask_t    wr_mask_i,
    input  logic                     req_i,
    input  vec_op_pkg::instr_type_t  op_i,
    input  vec_op_pkg::sew_t         sew_i,
    input  logic                     use_mask_i,
    input  vec_types_pkg::word_idx_t rd_addr_i,
    output logic                     ack_o,
    output vec_types_pkg::bus64_t    rd_data_o
);
    import vec_types_pkg::*;

    logic      cnt_clear;
    logic      cnt_step;
    logic      last_word;
    logic      res_we;
    word_idx_t word_idx;   // current word of the group
    bus64_t    op_vs2;
    bus64_t    op_vs1;
    vmask_t    op_mask;
    bus64_t    vd;

    operand_bank u_operand_bank (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (wr_en_i),
        .wr_addr_i (wr_addr_i),
        .wr_vs2_i  (wr_vs2_i),
        .wr_vs1_i  (wr_vs1_i),
        .wr_mask_i (wr_mask_i),
        .busy_i    (req_i | ack_o),  // handshake open
        .rd_addr_i (word_idx),
        .vs2_o     (op_vs2),
        .vs1_o     (op_vs1),
        .mask_o    (op_mask)
    );

    elem_counter u_elem_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .clear_i (cnt_clear),
        .step_i  (cnt_step),
        .idx_o   (word_idx),
        .last_o  (last_word)
    );

    addsub_ctrl u_addsub_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .last_i      (last_word),
        .op_i        (op_i),
        .sew_i       (sew_i),
        .use_mask_i  (use_mask_i),
        .ack_o       (ack_o),
        .cnt_clear_o (cnt_clear),
        .cnt_step_o  (cnt_step),
        .res_we_o    (res_we)
    );

    vaddsub u_vaddsub (
        .instr_type_i (op_i),
        .sew_i        (sew_i),
        .use_mask_i   (use_mask_i),
        .data_vs1_i   (op_vs1),
        .data_vs2_i   (op_vs2),
        .data_vm_i    (op_mask),
        .data_vd_o    (vd)
    );

    result_bank u_result_bank (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .we_i      (res_we),
        .wr_addr_i (word_idx),
        .wr_data_i (vd),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o)
    );

endmodule

`default_nettype wire

/* source/vec_op_pkg.sv */
// operation and element-width encodings
`default_nettype none

package vec_op_pkg;

    // add/subtract family
    typedef enum logic [2:0] {
        VADD  = 3'd0,
        VSUB  = 3'd1,  // vs2 - vs1
        VRSUB = 3'd2,  // vs1 - vs2
        VADC  = 3'd3,  // vs2 + vs1 + carry
        VSBC  = 3'd4,  // vs2 - vs1 - borrow
        VMADC = 3'd5,  // carry out only
        VMSBC = 3'd6   // borrow out only
    } instr_type_t;

    // element width, value is log2 of the bytes per element
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

endpackage

`default_nettype wire

/* source/vec_types_pkg.sv */
// word, mask and index widths, vector typedefs and group-size constants
`default_nettype none

package vec_types_pkg;

    // group geometry
    localparam int NUM_WORDS = 4;                  // operand words per operation group
    localparam int NUM_BYTES = 8;                  // byte lanes per word
    localparam int WORD_W    = 8 * NUM_BYTES;      // bits per word
    localparam int IDX_W     = $clog2(NUM_WORDS);  // word address width

    // one packed operand or result word
    typedef logic [WORD_W-1:0] bus64_t;

    // mask/carry byte, bit k belongs to element k
    typedef logic [NUM_BYTES-1:0] vmask_t;

    // word address inside the group
    typedef logic [IDX_W-1:0] word_idx_t;

endpackage

`default_nettype wire

/* tb/tb_vec_addsub_unit.sv */
// testbench for the vector add/subtract unit with directed tests and a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_vec_addsub_unit;
    import vec_types_pkg::*;
    import vec_op_pkg::*;

    localparam int          SEED           = 32'h582463d7;
    localparam int          NUM_OPS        = 54;   // 12 arith, 8 carry-in, 32 mask, 2 replace
    localparam int          CYCLES_PER_OP  = 20;
    localparam int          MARGIN         = 100;  // reset and read-back of the cleared banks
    localparam int          TIMEOUT_CYCLES = NUM_OPS * CYCLES_PER_OP + MARGIN;
    localparam int          HOLD_CYCLES    = 2;    // req kept high after ack

    logic        clk_i;
    logic        rst_n_i;
    logic        wr_en_i;
    word_idx_t   wr_addr_i;
    bus64_t      wr_vs2_i;
    bus64_t      wr_vs1_i;
    vmask_t      wr_mask_i;
    logic        req_i;
    instr_type_t op_i;
    sew_t        sew_i;
    logic        use_mask_i;
    word_idx_t   rd_addr_i;
    logic        ack_o;
    bus64_t      rd_data_o;

    int errors      = 0;
    int checks      = 0;
    int cycle_count = 0;

    // operand group as loaded into the DUT
    bus64_t grp_vs2  [NUM_WORDS];
    bus64_t grp_vs1  [NUM_WORDS];
    vmask_t grp_mask [NUM_WORDS];

    vec_addsub_unit dut (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (wr_en_i),
        .wr_addr_i  (wr_addr_i),
        .wr_vs2_i   (wr_vs2_i),
        .wr_vs1_i   (wr_vs1_i),
        .wr_mask_i  (wr_mask_i),
        .req_i      (req_i),
        .op_i       (op_i),
        .sew_i      (sew_i),
        .use_mask_i (use_mask_i),
        .rd_addr_i  (rd_addr_i),
        .ack_o      (ack_o),
        .rd_data_o  (rd_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns period
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped answering", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s, got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // a one in the lowest bit of every element
    function automatic bus64_t elem_ones(input sew_t sew);
        bus64_t r;
        r = '0;
        for (int k = 0; k < (NUM_BYTES >> sew); k++) begin
            r = r | (64'd1 << (k * (8 << sew)));
        end
        return r;
    endfunction

    // element-wise model of one result word
    function automatic bus64_t expected_word(input instr_type_t op, input sew_t sew,
                                             input logic use_mask, input bus64_t vs2,
                                             input bus64_t vs1, input vmask_t mask);
        int          w;
        logic [64:0] a;
        logic [64:0] b;
        logic [64:0] cb;  // carry or borrow into the element
        logic [64:0] r;
        bus64_t      emask;
        bus64_t      res;
        vmask_t      flags;
        w     = 8 << sew;
        emask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
        res   = '0;
        flags = '1;  // ones above the last element
        for (int k = 0; k < (NUM_BYTES >> sew); k++) begin
            a  = {1'b0, (vs2 >> (k * w)) & emask};
            b  = {1'b0, (vs1 >> (k * w)) & emask};
            cb = {64'd0, mask[k]};
            if ((op == VMADC || op == VMSBC) && !use_mask) begin
                cb = '0;
            end
            case (op)
                VADD:        r = a + b;
                VSUB:        r = a - b;
                VRSUB:       r = b - a;
                VADC, VMADC: r = a + b + cb;
                VSBC:        r = a - b - cb;
                default:     r = '0;
            endcase
            res = res | ((r[63:0] & emask) << (k * w));
            if (op == VMADC) begin
                flags[k] = r[w];  // carry is bit SEW
            end else if (op == VMSBC) begin
                flags[k] = (b + cb > a);
            end
        end
        if (op == VMADC || op == VMSBC) begin
            return {{(64 - NUM_BYTES){1'b1}}, flags};
        end else begin
            return res;
        end
    endfunction

    task automatic fill_random();
        for (int i = 0; i < NUM_WORDS; i++) begin
            grp_vs2[i]  = {$urandom, $urandom};
            grp_vs1[i]  = {$urandom, $urandom};
            grp_mask[i] = 8'($urandom);
        end
    endtask

    task automatic fill_edges(input sew_t sew);
        grp_vs2[0]  = '1;              // all ones plus one
        grp_vs1[0]  = elem_ones(sew);
        grp_mask[0] = '0;
        grp_vs2[1]  = '0;              // zero minus one
        grp_vs1[1]  = elem_ones(sew);
        grp_mask[1] = '0;
        grp_vs2[2]  = '1;              // carry only from the mask
        grp_vs1[2]  = '0;
        grp_mask[2] = '1;
        grp_vs2[3]  = '0;              // borrow only from the mask
        grp_vs1[3]  = '0;
        grp_mask[3] = '1;
    endtask

    task automatic load_group();
        for (int i = 0; i < NUM_WORDS; i++) begin
            @(posedge clk_i);
            #1;
            wr_en_i   = 1'b1;
            wr_addr_i = word_idx_t'(i);
            wr_vs2_i  = grp_vs2[i];
            wr_vs1_i  = grp_vs1[i];
            wr_mask_i = grp_mask[i];
        end
        @(posedge clk_i);  // last word stored here
        #1;
        wr_en_i = 1'b0;
    endtask

    // full four-phase handshake with timing checks on ack
    task automatic run_op(input instr_type_t op, input sew_t sew, input logic use_mask);
        int lat;
        @(posedge clk_i);
        #1;
        op_i       = op;
        sew_i      = sew;
        use_mask_i = use_mask;
        req_i      = 1'b1;
        @(posedge clk_i);  // req sampled in IDLE
        lat = 0;
        do begin
            @(posedge clk_i);
            #1;
            lat++;
        end while (!ack_o);
        compare(64'(lat), 64'(NUM_WORDS), "ack latency in cycles");
        repeat (HOLD_CYCLES) begin
            @(posedge clk_i);
            #1;
            compare(64'(ack_o), 64'd1, "ack held while req high");
        end
        req_i = 1'b0;
        @(posedge clk_i);
        #1;
        compare(64'(ack_o), 64'd0, "ack dropped after req low");
    endtask

    task automatic read_check(input instr_type_t op, input sew_t sew, input logic use_mask);
        bus64_t expected;
        for (int i = 0; i < NUM_WORDS; i++) begin
            expected = expected_word(op, sew, use_mask, grp_vs2[i], grp_vs1[i], grp_mask[i]);
            @(posedge clk_i);
            #1;
            rd_addr_i = word_idx_t'(i);
            @(negedge clk_i);
            compare(rd_data_o, expected, $sformatf("%s sew %0d masked %0d word %0d",
                                                   op.name(), 8 << sew, use_mask, i));
        end
    endtask

    task automatic run_and_check(input instr_type_t op, input sew_t sew, input logic use_mask);
        load_group();
        run_op(op, sew, use_mask);
        read_check(op, sew, use_mask);
    endtask

    task automatic test_reset_state();
        compare(64'(ack_o), 64'd0, "ack after reset");
        for (int i = 0; i < NUM_WORDS; i++) begin
            @(posedge clk_i);
            #1;
            rd_addr_i = word_idx_t'(i);
            @(negedge clk_i);
            compare(rd_data_o, '0, $sformatf("result word %0d after reset", i));
        end
    endtask

    task automatic test_arith();
        instr_type_t ops [3];
        ops = '{VADD, VSUB, VRSUB};
        foreach (ops[o]) begin
            for (int s = 0; s < 4; s++) begin
                fill_random();
                run_and_check(ops[o], sew_t'(s), 1'b0);
            end
        end
    endtask

    task automatic test_carry_in();
        for (int s = 0; s < 4; s++) begin
            fill_random();
            run_and_check(VADC, sew_t'(s), 1'b0);
            fill_random();
            run_and_check(VSBC, sew_t'(s), 1'b0);
        end
    endtask

    task automatic test_mask_ops();
        instr_type_t ops [2];
        ops = '{VMADC, VMSBC};
        foreach (ops[o]) begin
            for (int m = 0; m < 2; m++) begin
                for (int s = 0; s < 4; s++) begin
                    fill_random();
                    run_and_check(ops[o], sew_t'(s), 1'(m));
                    fill_edges(sew_t'(s));
                    run_and_check(ops[o], sew_t'(s), 1'(m));
                end
            end
        end
    endtask

    // second group overwrites every result word of the first
    task automatic test_replace();
        fill_random();
        run_and_check(VADD, SEW_64, 1'b0);
        fill_random();
        run_and_check(VSUB, SEW_16, 1'b0);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n_i    = 1'b0;
        wr_en_i    = 1'b0;
        wr_addr_i  = '0;
        wr_vs2_i   = '0;
        wr_vs1_i   = '0;
        wr_mask_i  = '0;
        req_i      = 1'b0;
        op_i       = VADD;
        sew_i      = SEW_8;
        use_mask_i = 1'b0;
        rd_addr_i  = '0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        test_reset_state();
        test_arith();
        test_carry_in();
        test_mask_ops();
        test_replace();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
